// ==== source/vec_pkg.sv ====
////////////////////
// Vector coprocessor shared definitions
// Sizes, element types, opcodes and the instruction and response
// records used between the core, the dispatcher and the lanes
////////////////////

package vec_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Parallel lanes
  localparam int unsigned NrLanes      = 4;
  // Element width in bits
  localparam int unsigned ElemWidth    = 32;
  // Elements per vector register
  localparam int unsigned MaxVl        = 16;
  // Elements of one register held by each lane
  localparam int unsigned ElemsPerLane = MaxVl / NrLanes;
  localparam int unsigned NrVRegs      = 8;
  // Also the number of credits the core holds after reset
  localparam int unsigned QueueDepth   = 4;
  localparam int unsigned TagWidth     = 4;

  ////////////////////
  // Plain types
  ////////////////////

  typedef logic [ElemWidth-1:0]              elem_t;
  typedef logic [$clog2(NrVRegs)-1:0]        vreg_idx_t;
  // Holds 0 up to MaxVl inclusive
  typedef logic [$clog2(MaxVl+1)-1:0]        vl_t;
  typedef logic [$clog2(ElemsPerLane)-1:0]   lane_idx_t;
  typedef logic [TagWidth-1:0]               tag_t;

  // Dispatcher queue pointer and occupancy
  typedef logic [$clog2(QueueDepth)-1:0]     qptr_t;
  typedef logic [$clog2(QueueDepth+1)-1:0]   qcnt_t;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [1:0] {
    OP_SPLAT,
    OP_ADD,
    OP_XOR,
    OP_REDSUM
  } vec_op_e;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    RESP
  } seq_state_e;

  ////////////////////
  // Records
  ////////////////////

  // Instruction from the core, forwarded unchanged to the lanes
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
    vl_t       vl;
    tag_t      tag;
  } vec_insn_t;

  // Scalar response, one per instruction
  typedef struct packed {
    tag_t  tag;
    elem_t result;
  } vec_resp_t;

endpackage

// ==== source/vec_dispatcher.sv ====
////////////////////
// Vector instruction dispatcher
// Queues core instructions, hands them to the sequencer in order
// and returns one credit per instruction that leaves the queue
////////////////////

module vec_dispatcher (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Core side
  input  logic                insn_valid_i,
  input  vec_pkg::vec_insn_t  insn_i,
  output logic                credit_o,
  // Sequencer side
  output logic                seq_req_valid_o,
  output vec_pkg::vec_insn_t  seq_req_o,
  input  logic                seq_req_ready_i
);

  ////////////////////
  // Queue storage
  ////////////////////

  vec_pkg::vec_insn_t queue_q [vec_pkg::QueueDepth];

  vec_pkg::qptr_t wr_ptr_q;
  vec_pkg::qptr_t rd_ptr_q;
  vec_pkg::qcnt_t count_q;

  logic push;
  logic pop;

  // The core only sends while it holds a credit, so a push never hits a full queue
  assign push = insn_valid_i;
  assign pop  = seq_req_valid_o && seq_req_ready_i;

  ////////////////////
  // Outputs
  ////////////////////

  // Oldest entry goes to the sequencer
  assign seq_req_valid_o = (count_q != '0);
  assign seq_req_o       = queue_q[rd_ptr_q];

  // One credit back per entry handed over
  assign credit_o = pop;

  ////////////////////
  // Pointers and count
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Entry write
  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_q[wr_ptr_q] <= insn_i;
    end
  end

endmodule

// ==== source/vec_sequencer.sv ====
////////////////////
// Vector sequencer
// Runs one instruction at a time on all lanes, then folds the
// lane partials into a tagged scalar response
////////////////////

module vec_sequencer (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  // Dispatcher side
  input  logic                                       seq_req_valid_i,
  input  vec_pkg::vec_insn_t                         seq_req_i,
  output logic                                       seq_req_ready_o,
  // Lane side
  output logic                                       lane_start_o,
  output vec_pkg::vec_insn_t                         lane_req_o,
  input  logic [vec_pkg::NrLanes-1:0]                lane_done_i,
  input  vec_pkg::elem_t [vec_pkg::NrLanes-1:0]      lane_partial_i,
  // Core side
  output logic                                       resp_valid_o,
  output vec_pkg::vec_resp_t                         resp_o
);

  vec_pkg::seq_state_e state_q;
  logic                lane_start_q;
  vec_pkg::vec_insn_t  insn_q;
  vec_pkg::vec_resp_t  resp_q;

  logic           req_fire;
  logic           all_done;
  vec_pkg::elem_t red_total;

  assign seq_req_ready_o = (state_q == vec_pkg::IDLE);
  assign req_fire        = seq_req_valid_i && seq_req_ready_o;

  // Lanes still show done during the start pulse, so skip that cycle
  assign all_done = !lane_start_q && (&lane_done_i);

  ////////////////////
  // Reduction fold
  ////////////////////

  always_comb begin
    red_total = insn_q.scalar;
    for (int unsigned l = 0; l < vec_pkg::NrLanes; l++) begin
      red_total = red_total + lane_partial_i[l];
    end
  end

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= vec_pkg::IDLE;
      lane_start_q <= 1'b0;
    end else begin
      lane_start_q <= 1'b0;
      case (state_q)
        vec_pkg::IDLE: begin
          if (req_fire) begin
            state_q      <= vec_pkg::RUN;
            lane_start_q <= 1'b1;
          end
        end
        vec_pkg::RUN: begin
          if (all_done) begin
            state_q <= vec_pkg::RESP;
          end
        end
        vec_pkg::RESP: begin
          state_q <= vec_pkg::IDLE;
        end
        default: begin
          state_q <= vec_pkg::IDLE;
        end
      endcase
    end
  end

  // Instruction held stable for the lanes while they run
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      insn_q <= seq_req_i;
    end
    if ((state_q == vec_pkg::RUN) && all_done) begin
      resp_q.tag    <= insn_q.tag;
      // Only reductions carry a scalar result
      resp_q.result <= (insn_q.op == vec_pkg::OP_REDSUM) ? red_total : '0;
    end
  end

  assign lane_start_o = lane_start_q;
  assign lane_req_o   = insn_q;
  assign resp_valid_o = (state_q == vec_pkg::RESP);
  assign resp_o       = resp_q;

endmodule

// ==== source/vec_lane.sv ====
////////////////////
// Vector lane
// Holds one slice of the register file and walks its active
// elements one per cycle through a small integer ALU
////////////////////

module vec_lane #(
  parameter int unsigned LaneId = 0
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Sequencer side
  input  logic                lane_start_i,
  input  vec_pkg::vec_insn_t  lane_req_i,
  output logic                lane_done_o,
  output vec_pkg::elem_t      lane_partial_o
);

  ////////////////////
  // Register file slice
  ////////////////////

  // Element i of a register sits at offset i / NrLanes of lane i % NrLanes
  vec_pkg::elem_t vrf_q [vec_pkg::NrVRegs][vec_pkg::ElemsPerLane];

  logic               done_q;
  vec_pkg::lane_idx_t off_q;
  vec_pkg::elem_t     acc_q;

  logic           busy;
  logic           last_elem;
  vec_pkg::vl_t   elem_idx;
  vec_pkg::vl_t   next_idx;
  vec_pkg::elem_t op_a;
  vec_pkg::elem_t op_b;
  vec_pkg::elem_t alu_res;

  assign busy = !done_q;

  // Global index of the element under work and of the next one in this lane
  assign elem_idx = vec_pkg::vl_t'(off_q) * vec_pkg::vl_t'(vec_pkg::NrLanes)
                    + vec_pkg::vl_t'(LaneId);
  assign next_idx = elem_idx + vec_pkg::vl_t'(vec_pkg::NrLanes);

  // Stop on the last offset or once the next element falls into the tail
  assign last_elem = (off_q == vec_pkg::lane_idx_t'(vec_pkg::ElemsPerLane - 1))
                     || (next_idx >= lane_req_i.vl);

  ////////////////////
  // ALU
  ////////////////////

  assign op_a = vrf_q[lane_req_i.vs1][off_q];
  assign op_b = vrf_q[lane_req_i.vs2][off_q];

  always_comb begin
    case (lane_req_i.op)
      vec_pkg::OP_SPLAT: alu_res = lane_req_i.scalar;
      vec_pkg::OP_ADD:   alu_res = op_a + op_b;
      vec_pkg::OP_XOR:   alu_res = op_a ^ op_b;
      default:           alu_res = op_b;
    endcase
  end

  ////////////////////
  // Element iterator
  ////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= 1'b1;
      off_q  <= '0;
    end else if (lane_start_i) begin
      // No active element here when vl does not reach this lane
      done_q <= (lane_req_i.vl <= vec_pkg::vl_t'(LaneId));
      off_q  <= '0;
    end else if (busy) begin
      if (last_elem) begin
        done_q <= 1'b1;
      end else begin
        off_q <= off_q + 1'b1;
      end
    end
  end

  // Write back or accumulate, one element per busy cycle
  always_ff @(posedge clk_i) begin
    if (lane_start_i) begin
      acc_q <= '0;
    end else if (busy) begin
      if (lane_req_i.op == vec_pkg::OP_REDSUM) begin
        acc_q <= acc_q + op_b;
      end else begin
        vrf_q[lane_req_i.vd][off_q] <= alu_res;
      end
    end
  end

  assign lane_done_o    = done_q;
  assign lane_partial_o = acc_q;

endmodule

// ==== source/vec_unit.sv ====
////////////////////
// Vector coprocessor top level
// Dispatcher, sequencer and a row of parallel lanes
////////////////////

module vec_unit (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Core instruction port, credit based
  input  logic                insn_valid_i,
  input  vec_pkg::vec_insn_t  insn_i,
  output logic                credit_o,
  // Core response port
  output logic                resp_valid_o,
  output vec_pkg::vec_resp_t  resp_o
);

  ////////////////////
  // Dispatcher
  ////////////////////

  logic               seq_req_valid;
  logic               seq_req_ready;
  vec_pkg::vec_insn_t seq_req;

  vec_dispatcher i_dispatcher (
    .clk_i           (clk_i        ),
    .arst_n_i        (arst_n_i     ),
    .insn_valid_i    (insn_valid_i ),
    .insn_i          (insn_i       ),
    .credit_o        (credit_o     ),
    .seq_req_valid_o (seq_req_valid),
    .seq_req_o       (seq_req      ),
    .seq_req_ready_i (seq_req_ready)
  );

  ////////////////////
  // Sequencer
  ////////////////////

  logic                                  lane_start;
  vec_pkg::vec_insn_t                    lane_req;
  logic [vec_pkg::NrLanes-1:0]           lane_done;
  vec_pkg::elem_t [vec_pkg::NrLanes-1:0] lane_partial;

  vec_sequencer i_sequencer (
    .clk_i           (clk_i        ),
    .arst_n_i        (arst_n_i     ),
    .seq_req_valid_i (seq_req_valid),
    .seq_req_i       (seq_req      ),
    .seq_req_ready_o (seq_req_ready),
    .lane_start_o    (lane_start   ),
    .lane_req_o      (lane_req     ),
    .lane_done_i     (lane_done    ),
    .lane_partial_i  (lane_partial ),
    .resp_valid_o    (resp_valid_o ),
    .resp_o          (resp_o       )
  );

  ////////////////////
  // Lanes
  ////////////////////

  for (genvar lane = 0; lane < vec_pkg::NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .LaneId (lane)
    ) i_lane (
      .clk_i          (clk_i             ),
      .arst_n_i       (arst_n_i          ),
      .lane_start_i   (lane_start        ),
      .lane_req_i     (lane_req          ),
      .lane_done_o    (lane_done[lane]   ),
      .lane_partial_o (lane_partial[lane])
    );
  end

endmodule

// ==== test/tb_vec_table.svh ====
////////////////////
// Vector unit test program
// Instructions in issue order with the scalar result expected for each
////////////////////

`ifndef TB_VEC_TABLE_SVH
`define TB_VEC_TABLE_SVH

localparam int unsigned NrEntries = 16;

// Rows fill the stimulus table, the row index is also the tag
task automatic load_table();
  // idx  op                    vd    vs1   vs2   scalar        vl     expected
  // Splat and reduction
  put_row(0,  vec_pkg::OP_SPLAT,  3'd1, 3'd0, 3'd0, 32'd3,        5'd16, 32'd0);
  put_row(1,  vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd1, 32'd5,        5'd16, 32'd53);
  // Add and XOR, checked through reductions
  put_row(2,  vec_pkg::OP_SPLAT,  3'd2, 3'd0, 3'd0, 32'd7,        5'd16, 32'd0);
  put_row(3,  vec_pkg::OP_ADD,    3'd3, 3'd1, 3'd2, 32'd0,        5'd16, 32'd0);
  put_row(4,  vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd3, 32'd0,        5'd16, 32'd160);
  put_row(5,  vec_pkg::OP_XOR,    3'd4, 3'd1, 3'd2, 32'd0,        5'd16, 32'd0);
  put_row(6,  vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd4, 32'd0,        5'd16, 32'd64);
  // Tail undisturbed, v5 holds six ones then ten twos
  put_row(7,  vec_pkg::OP_SPLAT,  3'd5, 3'd0, 3'd0, 32'd2,        5'd16, 32'd0);
  put_row(8,  vec_pkg::OP_SPLAT,  3'd5, 3'd0, 3'd0, 32'd1,        5'd6,  32'd0);
  put_row(9,  vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd5, 32'd0,        5'd16, 32'd26);
  // Zero length returns the scalar as is
  put_row(10, vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd5, 32'h0000_1234, 5'd0, 32'h0000_1234);
  // Short reduction over v3, three tens plus one
  put_row(11, vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd3, 32'd1,        5'd3,  32'd31);
  // v6 is six twos then ten fours
  put_row(12, vec_pkg::OP_ADD,    3'd6, 3'd5, 3'd5, 32'd0,        5'd16, 32'd0);
  put_row(13, vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd6, 32'd0,        5'd9,  32'd24);
  // v7 is six ones then ten sevens, sum 76 minus 16 wraps
  put_row(14, vec_pkg::OP_XOR,    3'd7, 3'd6, 3'd1, 32'd0,        5'd16, 32'd0);
  put_row(15, vec_pkg::OP_REDSUM, 3'd0, 3'd0, 3'd7, 32'hFFFF_FFF0, 5'd16, 32'd60);
endtask

`endif

// ==== test/tb_vec_unit.sv ====
////////////////////
// Vector unit testbench
// Credit based driver over a stimulus table and an in-order
// response checker
////////////////////

module tb_vec_unit;

  localparam int unsigned Timeout = 200;

  logic                clk;
  logic                arst_n;
  logic                insn_valid;
  vec_pkg::vec_insn_t  insn;
  logic                credit;
  logic                resp_valid;
  vec_pkg::vec_resp_t  resp;

  vec_pkg::vec_insn_t insn_tbl [16];
  vec_pkg::elem_t     exp_tbl  [16];

  int credits       = vec_pkg::QueueDepth;
  int sent_count    = 0;
  int credit_pulses = 0;
  int resp_idx      = 0;
  int seed          = 57047;

  vec_unit vec_unit_i (
    .clk_i        (clk       ),
    .arst_n_i     (arst_n    ),
    .insn_valid_i (insn_valid),
    .insn_i       (insn      ),
    .credit_o     (credit    ),
    .resp_valid_o (resp_valid),
    .resp_o       (resp      )
  );

  ////////////////////
  // Helpers
  ////////////////////

  task automatic stop_with(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic put_row(input int idx, input vec_pkg::vec_op_e op,
                         input vec_pkg::vreg_idx_t vd, input vec_pkg::vreg_idx_t vs1,
                         input vec_pkg::vreg_idx_t vs2, input vec_pkg::elem_t scalar,
                         input vec_pkg::vl_t vl, input vec_pkg::elem_t expected);
    insn_tbl[idx].op     = op;
    insn_tbl[idx].vd     = vd;
    insn_tbl[idx].vs1    = vs1;
    insn_tbl[idx].vs2    = vs2;
    insn_tbl[idx].scalar = scalar;
    insn_tbl[idx].vl     = vl;
    insn_tbl[idx].tag    = vec_pkg::tag_t'(idx);
    exp_tbl[idx]         = expected;
  endtask

  `include "tb_vec_table.svh"

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // Driver
  ////////////////////

  initial begin : drive_program
    int gap;
    int waited;
    arst_n     = 1'b0;
    insn_valid = 1'b0;
    insn       = '0;
    load_table();
    repeat (4) @(posedge clk);
    #1 arst_n = 1'b1;
    // Quiet period to see the outputs stay low
    repeat (3) @(posedge clk);
    #1;
    for (int i = 0; i < int'(NrEntries); i++) begin
      gap = int'($unsigned($random(seed)) % 4);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      waited = 0;
      while (credits == 0) begin
        @(posedge clk);
        #1;
        waited++;
        assert (waited < int'(Timeout))
          else stop_with("Timed out waiting for a credit from the dispatcher");
      end
      insn_valid = 1'b1;
      insn       = insn_tbl[i];
      credits--;
      sent_count++;
      @(posedge clk);
      #1 insn_valid = 1'b0;
    end
    waited = 0;
    while (resp_idx < int'(NrEntries)) begin
      @(posedge clk);
      waited++;
      assert (waited < int'(Timeout))
        else stop_with("Timed out waiting for the final response");
    end
    assert (credit_pulses == int'(NrEntries))
      else stop_with($sformatf("ERR t=%0t: %0d credits returned for %0d instructions",
                               $time, credit_pulses, NrEntries));
    $display("Simulation completed successfully");
    $finish;
  end

  ////////////////////
  // Checker
  ////////////////////

  // Outputs are sampled mid cycle, away from the driving edge
  initial begin : check_outputs
    forever begin
      @(negedge clk);
      if (arst_n) begin
        if (sent_count == 0) begin
          assert (!credit && !resp_valid)
            else stop_with($sformatf("ERR t=%0t: output active before any instruction",
                                     $time));
        end
        if (credit) begin
          credit_pulses++;
          credits++;
        end
        assert (credits <= int'(vec_pkg::QueueDepth))
          else stop_with($sformatf("ERR t=%0t: credit count %0d above queue depth",
                                   $time, credits));
        // Only one instruction may have left the queue without its response
        assert (credit_pulses - resp_idx <= 1)
          else stop_with($sformatf("ERR t=%0t: %0d instructions in the sequencer at once",
                                   $time, credit_pulses - resp_idx));
        if (resp_valid) begin
          assert (resp_idx < sent_count)
            else stop_with("A response arrived with no instruction outstanding");
          assert (resp.tag == insn_tbl[resp_idx].tag)
            else stop_with($sformatf("ERR t=%0t: tag %0d, expected %0d",
                                     $time, resp.tag, insn_tbl[resp_idx].tag));
          assert (resp.result == exp_tbl[resp_idx])
            else stop_with($sformatf("ERR t=%0t: tag %0d result 0x%08h, expected 0x%08h",
                                     $time, resp.tag, resp.result, exp_tbl[resp_idx]));
          resp_idx++;
        end
      end
    end
  end

endmodule

// ==== vec_unit.f ====
+incdir+test
source/vec_pkg.sv
source/vec_dispatcher.sv
source/vec_sequencer.sv
source/vec_lane.sv
source/vec_unit.sv
test/tb_vec_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the vector unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
  -f vec_unit.f \
  --top-module tb_vec_unit \
  -o sim_vec_unit

./obj_dir/sim_vec_unit
